// ==== src/lanemix_pkg.sv ====
// lane mixer shared types

package lanemix_pkg;

	// stream word
	localparam int data_w = 32;
	localparam int quarter_w = data_w / 4; // rotate step

	typedef logic [data_w-1:0] data_t;

	// datapath shape
	localparam int lanes = 5;  // parallel taps and lanes
	localparam int stages = 4; // transform stages per lane

	// transform stage kinds
	typedef enum logic [2:0] {
		sk_reg,  // pass through
		sk_inv,  // bitwise complement
		sk_add,  // running sum
		sk_gray, // gray encode
		sk_rot,  // quarter-word rotate by low bits
		sk_mem   // delay ring
	} stage_kind_t;

endpackage

// ==== src/tap_shifter.sv ====
// input tap shifter

`timescale 1ns/1ps

module tap_shifter (
	input  logic               clk,
	input  logic               rst,
	input  lanemix_pkg::data_t in,
	output lanemix_pkg::data_t tap0,
	output lanemix_pkg::data_t tap1,
	output lanemix_pkg::data_t tap2,
	output lanemix_pkg::data_t tap3,
	output lanemix_pkg::data_t tap4
);

	lanemix_pkg::data_t hist [lanemix_pkg::lanes]; // newest word at 0

	// word history, one position per clock
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < lanemix_pkg::lanes; i++) begin
				hist[i] <= '0;
			end
		end else begin
			hist[0] <= in;
			for (int i = 1; i < lanemix_pkg::lanes; i++) begin
				hist[i] <= hist[i-1];
			end
		end
	end

	// taps lag the history by one more cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tap0 <= '0;
			tap1 <= '0;
			tap2 <= '0;
			tap3 <= '0;
			tap4 <= '0;
		end else begin
			tap0 <= hist[0]; // in from 2 cycles back
			tap1 <= hist[1];
			tap2 <= hist[2];
			tap3 <= hist[3];
			tap4 <= hist[4]; // in from 6 cycles back
		end
	end

endmodule

// ==== src/xform_stage.sv ====
// registered transform stage

`timescale 1ns/1ps

module xform_stage #(
	parameter lanemix_pkg::stage_kind_t KIND = lanemix_pkg::sk_reg,
	parameter int unsigned MEM_DEPTH = 4
) (
	input  logic               clk,
	input  logic               rst,
	input  lanemix_pkg::data_t d,
	output lanemix_pkg::data_t q
);

	localparam int dw = lanemix_pkg::data_w;
	localparam int qw = lanemix_pkg::quarter_w;

	case (KIND)

		lanemix_pkg::sk_reg: begin : g_reg
			always_ff @(posedge clk or posedge rst) begin
				if (rst)
					q <= '0;
				else
					q <= d;
			end
		end

		lanemix_pkg::sk_inv: begin : g_inv
			always_ff @(posedge clk or posedge rst) begin
				if (rst)
					q <= '0;
				else
					q <= ~d;
			end
		end

		lanemix_pkg::sk_add: begin : g_add
			// output doubles as the accumulator, wraps mod 2^dw
			always_ff @(posedge clk or posedge rst) begin
				if (rst)
					q <= '0;
				else
					q <= q + d;
			end
		end

		lanemix_pkg::sk_gray: begin : g_gray
			always_ff @(posedge clk or posedge rst) begin
				if (rst)
					q <= '0;
				else
					q <= d ^ (d >> 1);
			end
		end

		lanemix_pkg::sk_rot: begin : g_rot
			lanemix_pkg::data_t rot;

			// rotate left by d[1:0] quarter words
			always_comb begin
				case (d[1:0])
					2'd0: rot = d;
					2'd1: rot = {d[dw-qw-1:0], d[dw-1:dw-qw]};
					2'd2: rot = {d[dw-2*qw-1:0], d[dw-1:dw-2*qw]};
					default: rot = {d[dw-3*qw-1:0], d[dw-1:dw-3*qw]};
				endcase
			end

			always_ff @(posedge clk or posedge rst) begin
				if (rst)
					q <= '0;
				else
					q <= rot;
			end
		end

		lanemix_pkg::sk_mem: begin : g_mem
			localparam int ptr_w = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

			logic [ptr_w-1:0] ptr;
			lanemix_pkg::data_t ring [MEM_DEPTH];

			// read old entry and overwrite it in the same cycle
			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					ptr <= '0;
					q <= '0;
					for (int i = 0; i < MEM_DEPTH; i++) begin
						ring[i] <= '0;
					end
				end else begin
					q <= ring[ptr];
					ring[ptr] <= d;
					if (ptr == ptr_w'(MEM_DEPTH - 1))
						ptr <= '0; // wrap
					else
						ptr <= ptr + ptr_w'(1);
				end
			end
		end

	endcase

endmodule

// ==== src/lane_pipe.sv ====
// four-stage processing lane

`timescale 1ns/1ps

module lane_pipe #(
	parameter lanemix_pkg::stage_kind_t KIND0 = lanemix_pkg::sk_reg,
	parameter lanemix_pkg::stage_kind_t KIND1 = lanemix_pkg::sk_reg,
	parameter lanemix_pkg::stage_kind_t KIND2 = lanemix_pkg::sk_reg,
	parameter lanemix_pkg::stage_kind_t KIND3 = lanemix_pkg::sk_reg,
	parameter int unsigned MEM_DEPTH = 4
) (
	input  logic               clk,
	input  logic               rst,
	input  lanemix_pkg::data_t d,
	output lanemix_pkg::data_t q
);

	localparam lanemix_pkg::stage_kind_t kinds [lanemix_pkg::stages] = '{
		KIND0,
		KIND1,
		KIND2,
		KIND3
	};

	// link[i] feeds stage i, last entry is the lane result
	lanemix_pkg::data_t link [lanemix_pkg::stages + 1];

	assign link[0] = d;

	for (genvar i = 0; i < lanemix_pkg::stages; i++) begin : g_stage
		xform_stage #(
			.KIND      (kinds[i]),
			.MEM_DEPTH (MEM_DEPTH)
		) u_stage (
			.clk (clk),
			.rst (rst),
			.d   (link[i]),
			.q   (link[i+1])
		);
	end

	assign q = link[lanemix_pkg::stages];

endmodule

// ==== src/xor_fold.sv ====
// output xor fold

`timescale 1ns/1ps

module xor_fold (
	input  logic               clk,
	input  logic               rst,
	input  lanemix_pkg::data_t l0,
	input  lanemix_pkg::data_t l1,
	input  lanemix_pkg::data_t l2,
	input  lanemix_pkg::data_t l3,
	input  lanemix_pkg::data_t l4,
	output lanemix_pkg::data_t out
);

	lanemix_pkg::data_t mix;

	assign mix = l0 ^ l1 ^ l2 ^ l3 ^ l4;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			out <= '0;
		else
			out <= mix; // one cycle after the lanes
	end

endmodule

// ==== src/lanemix_top.sv ====
// five-lane word mixer

`timescale 1ns/1ps

module lanemix_top #(
	parameter int unsigned MEM_DEPTH = 4
) (
	input  logic               clk,
	input  logic               rst,
	input  lanemix_pkg::data_t in,
	output lanemix_pkg::data_t out
);

	lanemix_pkg::data_t tap0, tap1, tap2, tap3, tap4;
	lanemix_pkg::data_t lane_out0, lane_out1, lane_out2, lane_out3, lane_out4;

	tap_shifter u_taps (
		.clk  (clk),
		.rst  (rst),
		.in   (in),
		.tap0 (tap0),
		.tap1 (tap1),
		.tap2 (tap2),
		.tap3 (tap3),
		.tap4 (tap4)
	);

	// lane 0: mem, add, reg, rot
	lane_pipe #(
		.KIND0     (lanemix_pkg::sk_mem),
		.KIND1     (lanemix_pkg::sk_add),
		.KIND2     (lanemix_pkg::sk_reg),
		.KIND3     (lanemix_pkg::sk_rot),
		.MEM_DEPTH (MEM_DEPTH)
	) u_lane0 (
		.clk (clk),
		.rst (rst),
		.d   (tap0),
		.q   (lane_out0)
	);

	lane_pipe #(
		.KIND0     (lanemix_pkg::sk_inv),
		.KIND1     (lanemix_pkg::sk_gray),
		.KIND2     (lanemix_pkg::sk_reg),
		.KIND3     (lanemix_pkg::sk_rot),
		.MEM_DEPTH (MEM_DEPTH)
	) u_lane1 (
		.clk (clk),
		.rst (rst),
		.d   (tap1),
		.q   (lane_out1)
	);

	// lane 2 also carries a delay ring
	lane_pipe #(
		.KIND0     (lanemix_pkg::sk_reg),
		.KIND1     (lanemix_pkg::sk_mem),
		.KIND2     (lanemix_pkg::sk_gray),
		.KIND3     (lanemix_pkg::sk_add),
		.MEM_DEPTH (MEM_DEPTH)
	) u_lane2 (
		.clk (clk),
		.rst (rst),
		.d   (tap2),
		.q   (lane_out2)
	);

	lane_pipe #(
		.KIND0     (lanemix_pkg::sk_inv),
		.KIND1     (lanemix_pkg::sk_rot),
		.KIND2     (lanemix_pkg::sk_gray),
		.KIND3     (lanemix_pkg::sk_add),
		.MEM_DEPTH (MEM_DEPTH)
	) u_lane3 (
		.clk (clk),
		.rst (rst),
		.d   (tap3),
		.q   (lane_out3)
	);

	lane_pipe #(
		.KIND0     (lanemix_pkg::sk_reg),
		.KIND1     (lanemix_pkg::sk_rot),
		.KIND2     (lanemix_pkg::sk_inv),
		.KIND3     (lanemix_pkg::sk_gray),
		.MEM_DEPTH (MEM_DEPTH)
	) u_lane4 (
		.clk (clk),
		.rst (rst),
		.d   (tap4),
		.q   (lane_out4)
	);

	xor_fold u_fold (
		.clk (clk),
		.rst (rst),
		.l0  (lane_out0),
		.l1  (lane_out1),
		.l2  (lane_out2),
		.l3  (lane_out3),
		.l4  (lane_out4),
		.out (out)
	);

endmodule

// ==== test/lanemix_model.svh ====
// lane mixer reference model

`ifndef LANEMIX_MODEL_SVH
`define LANEMIX_MODEL_SVH

// expects mem_depth from the including module

localparam lanemix_pkg::stage_kind_t kind_table [lanemix_pkg::lanes][lanemix_pkg::stages] = '{
	'{lanemix_pkg::sk_mem, lanemix_pkg::sk_add, lanemix_pkg::sk_reg, lanemix_pkg::sk_rot},
	'{lanemix_pkg::sk_inv, lanemix_pkg::sk_gray, lanemix_pkg::sk_reg, lanemix_pkg::sk_rot},
	'{lanemix_pkg::sk_reg, lanemix_pkg::sk_mem, lanemix_pkg::sk_gray, lanemix_pkg::sk_add},
	'{lanemix_pkg::sk_inv, lanemix_pkg::sk_rot, lanemix_pkg::sk_gray, lanemix_pkg::sk_add},
	'{lanemix_pkg::sk_reg, lanemix_pkg::sk_rot, lanemix_pkg::sk_inv, lanemix_pkg::sk_gray}
};

lanemix_pkg::data_t m_hist [lanemix_pkg::lanes]; // newest at 0
lanemix_pkg::data_t m_tap [lanemix_pkg::lanes];
lanemix_pkg::data_t m_stg [lanemix_pkg::lanes][lanemix_pkg::stages];
lanemix_pkg::data_t m_ring [lanemix_pkg::lanes][lanemix_pkg::stages][mem_depth];
int m_ptr [lanemix_pkg::lanes][lanemix_pkg::stages];
lanemix_pkg::data_t m_out;

// rotate left by low two bits times a quarter word
function automatic lanemix_pkg::data_t rotl_quarter(input lanemix_pkg::data_t d);
	int amt;
	amt = int'(d[1:0]) * (lanemix_pkg::data_w / 4);
	if (amt == 0)
		return d;
	return (d << amt) | (d >> (lanemix_pkg::data_w - amt));
endfunction

// result of every kind except the delay ring
function automatic lanemix_pkg::data_t next_stage_value(input lanemix_pkg::stage_kind_t kind,
		input lanemix_pkg::data_t d, input lanemix_pkg::data_t q);
	case (kind)
		lanemix_pkg::sk_inv: return ~d;
		lanemix_pkg::sk_add: return q + d; // wraps mod 2^32
		lanemix_pkg::sk_gray: return d ^ (d >> 1);
		lanemix_pkg::sk_rot: return rotl_quarter(d);
		default: return d;
	endcase
endfunction

task automatic reset_model();
	for (int l = 0; l < lanemix_pkg::lanes; l++) begin
		m_hist[l] = '0;
		m_tap[l] = '0;
		for (int s = 0; s < lanemix_pkg::stages; s++) begin
			m_stg[l][s] = '0;
			m_ptr[l][s] = 0;
			for (int e = 0; e < mem_depth; e++) begin
				m_ring[l][s][e] = '0;
			end
		end
	end
	m_out = '0;
endtask

// one rising edge; later registers update first so they see old values
task automatic step_model(input lanemix_pkg::data_t w);
	lanemix_pkg::data_t d;
	lanemix_pkg::data_t acc;
	acc = '0;
	for (int l = 0; l < lanemix_pkg::lanes; l++) begin
		acc ^= m_stg[l][lanemix_pkg::stages-1];
	end
	m_out = acc;
	for (int l = 0; l < lanemix_pkg::lanes; l++) begin
		for (int s = lanemix_pkg::stages - 1; s >= 0; s--) begin
			d = (s == 0) ? m_tap[l] : m_stg[l][s-1];
			if (kind_table[l][s] == lanemix_pkg::sk_mem) begin
				m_stg[l][s] = m_ring[l][s][m_ptr[l][s]];
				m_ring[l][s][m_ptr[l][s]] = d;
				m_ptr[l][s] = (m_ptr[l][s] + 1) % mem_depth;
			end else begin
				m_stg[l][s] = next_stage_value(kind_table[l][s], d, m_stg[l][s]);
			end
		end
	end
	for (int k = 0; k < lanemix_pkg::lanes; k++) begin
		m_tap[k] = m_hist[k];
	end
	for (int k = lanemix_pkg::lanes - 1; k > 0; k--) begin
		m_hist[k] = m_hist[k-1];
	end
	m_hist[0] = w;
endtask

`endif

// ==== test/lanemix_tb.sv ====
// lane mixer testbench

`timescale 1ns/1ps

module lanemix_tb;

	localparam int mem_depth = 4;
	localparam int clk_period = 4; // ns
	localparam int reset_cycles = 5;
	localparam int n_random = 2000;
	localparam int n_rot = 400;
	localparam int n_ones = 600;
	localparam int n_pre = 200;     // words before the mid-stream reset
	localparam int mid_reset_cycles = 3;
	localparam int n_post = 300;
	localparam int n_drain = 16;    // flushes the longest lane
	localparam int total_cycles = reset_cycles + 1 + n_random + n_rot + n_ones
		+ n_pre + mid_reset_cycles + 1 + n_post + n_drain;

	logic clk;
	logic rst;
	lanemix_pkg::data_t in;
	lanemix_pkg::data_t out;

	`include "lanemix_model.svh"

	lanemix_top #(
		.MEM_DEPTH (mem_depth)
	) DUT (
		.clk (clk),
		.rst (rst),
		.in  (in),
		.out (out)
	);

	always #(clk_period / 2) clk = ~clk;

	// model registers follow the DUT edge by edge
	always @(posedge clk) begin
		if (rst)
			reset_model();
		else
			step_model(in);
	end

	task automatic check_data(input string name, input lanemix_pkg::data_t got,
			input lanemix_pkg::data_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
			$display("Regression failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// compare on the falling edge, then present the next word
	task automatic drive_word(input lanemix_pkg::data_t w);
		@(negedge clk);
		check_data("out", out, m_out);
		in = w;
	endtask

	// called on a falling edge
	task automatic hold_reset(input int cycles);
		rst = 1'b1;
		reset_model();
		repeat (cycles) begin
			@(negedge clk);
			check_data("out during reset", out, '0);
		end
		rst = 1'b0;
		@(negedge clk);
		check_data("out after reset", out, '0); // nothing has reached the fold yet
		check_data("out", out, m_out);
	endtask

	initial begin : stimulus
		int unsigned seed;
		seed = 32'ha0c4;
		void'($urandom(seed));
		clk = 1'b0;
		rst = 1'b1;
		in = '0;
		reset_model();

		hold_reset(reset_cycles);

		repeat (n_random) drive_word($urandom());

		// every rotate amount in turn
		for (int i = 0; i < n_rot; i++) begin
			drive_word(($urandom() & 32'hffff_fffc) | lanemix_pkg::data_t'(i % 4));
		end

		repeat (n_ones) drive_word('1); // accumulators wrap

		repeat (n_pre) drive_word($urandom());
		hold_reset(mid_reset_cycles);
		repeat (n_post) drive_word($urandom());

		repeat (n_drain) drive_word('0);

		$display("Regression passed");
		$finish;
	end

	initial begin : watchdog
		#(total_cycles * clk_period * 2);
		$display("timeout: the run did not finish within %0d cycles", total_cycles * 2);
		$display("Regression failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== lanemix_top.f ====
+incdir+test
src/lanemix_pkg.sv
src/tap_shifter.sv
src/xform_stage.sv
src/lane_pipe.sv
src/xor_fold.sv
src/lanemix_top.sv
test/lanemix_tb.sv

// ==== Makefile ====
# Verilator build and run for the lane mixer

VERILATOR  ?= verilator
TOP        ?= lanemix_tb
RTL_TOP    ?= lanemix_top
FILELIST   ?= lanemix_top.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only
PASS_MSG   ?= Regression passed
RTL_SRCS   ?= src/lanemix_pkg.sv src/tap_shifter.sv src/xform_stage.sv \
              src/lane_pipe.sv src/xor_fold.sv src/lanemix_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
